// File: common/isaPkg.sv
package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [2:0]  funct3T;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OPIMM  = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcodeT;

    // Branch kinds
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;

    // ALU kinds for OP and OP-IMM
    localparam funct3T F3_ADD  = 3'b000;
    localparam funct3T F3_SLL  = 3'b001;
    localparam funct3T F3_SLT  = 3'b010;
    localparam funct3T F3_SLTU = 3'b011;
    localparam funct3T F3_XOR  = 3'b100;
    localparam funct3T F3_SR   = 3'b101;
    localparam funct3T F3_OR   = 3'b110;
    localparam funct3T F3_AND  = 3'b111;

endpackage

// File: common/pipePkg.sv
package pipePkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] wordT;

    localparam wordT RESET_PC = 32'h0000_0000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpT;

    // Operand source in execute
    typedef enum logic {
        REGVAL,
        FROMWB
    } fwdSelT;

endpackage

// File: common/deStageIf.sv
`timescale 1ns/1ps

interface deStageIf import isaPkg::*, pipePkg::*; ();

    logic    valid;
    logic    regWrite;
    aluOpT   aluCtrl;
    logic    aluSrc;
    logic    aSrcPc;
    logic    jump;
    logic    jalr;
    logic    branch;
    funct3T  funct3;
    wordT    rs1Val;
    wordT    rs2Val;
    wordT    pc;
    wordT    pcPlus4;
    wordT    immExt;
    regAddrT rd;
    regAddrT rs1;
    regAddrT rs2;

    modport src (
        output valid, regWrite, aluCtrl, aluSrc, aSrcPc, jump, jalr, branch, funct3,
        output rs1Val, rs2Val, pc, pcPlus4, immExt, rd, rs1, rs2
    );

    modport dst (
        input valid, regWrite, aluCtrl, aluSrc, aSrcPc, jump, jalr, branch, funct3,
        input rs1Val, rs2Val, pc, pcPlus4, immExt, rd, rs1, rs2
    );

endinterface

// File: design/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import isaPkg::*, pipePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stall,
    input  logic  flushD,
    input  logic  redirect,
    input  wordT  redirectPc,
    output wordT  imemAddr,
    input  instrT imemData,
    output instrT instrD,
    output wordT  pcD,
    output wordT  pcPlus4D,
    output logic  validD
);

    wordT pc;
    wordT pcPlus4;

    assign pcPlus4  = pc + 32'd4;
    assign imemAddr = pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= RESET_PC;
            validD <= 1'b0;
        end else if (!stall) begin
            pc     <= redirect ? redirectPc : pcPlus4;
            // Wrong-path fetch is dropped on a redirect
            validD <= !flushD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instrD   <= imemData;
            pcD      <= pc;
            pcPlus4D <= pcPlus4;
        end
    end

endmodule

// File: decode/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import isaPkg::*, pipePkg::*; (
    input  instrT   instrD,
    input  wordT    pcD,
    input  wordT    pcPlus4D,
    input  logic    validD,
    input  wordT    rs1Val,
    input  wordT    rs2Val,
    output regAddrT rs1Addr,
    output regAddrT rs2Addr,
    deStageIf.src   dIf
);

    opcodeT opcode;
    funct3T funct3;
    logic   supported;
    wordT   immI;
    wordT   immB;
    wordT   immU;
    wordT   immJ;

    // alt picks SUB over ADD and SRA over SRL
    function automatic aluOpT aluKind(funct3T f3, logic alt);
        case (f3)
            F3_ADD:  aluKind = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  aluKind = ALU_SLL;
            F3_SLT:  aluKind = ALU_SLT;
            F3_SLTU: aluKind = ALU_SLTU;
            F3_XOR:  aluKind = ALU_XOR;
            F3_SR:   aluKind = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   aluKind = ALU_OR;
            default: aluKind = ALU_AND;
        endcase
    endfunction

    assign opcode  = opcodeT'(instrD[6:0]);
    assign funct3  = instrD[14:12];
    assign rs1Addr = instrD[19:15];
    assign rs2Addr = instrD[24:20];

    assign immI = {{20{instrD[31]}}, instrD[31:20]};
    assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
    assign immU = {instrD[31:12], 12'b0};
    assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

    always_comb begin
        supported    = 1'b1;
        dIf.regWrite = 1'b0;
        dIf.aluCtrl  = ALU_ADD;
        dIf.aluSrc   = 1'b0;
        dIf.aSrcPc   = 1'b0;
        dIf.jump     = 1'b0;
        dIf.jalr     = 1'b0;
        dIf.branch   = 1'b0;
        dIf.immExt   = immI;
        case (opcode)
            OPC_OP: begin
                dIf.regWrite = 1'b1;
                dIf.aluCtrl  = aluKind(funct3, instrD[30]);
            end
            OPC_OPIMM: begin
                dIf.regWrite = 1'b1;
                dIf.aluSrc   = 1'b1;
                // Bit 30 is part of the immediate except for shifts right
                dIf.aluCtrl  = aluKind(funct3, instrD[30] && funct3 == F3_SR);
            end
            OPC_LUI: begin
                dIf.regWrite = 1'b1;
                dIf.aluSrc   = 1'b1;
                dIf.aluCtrl  = ALU_PASSB;
                dIf.immExt   = immU;
            end
            OPC_AUIPC: begin
                dIf.regWrite = 1'b1;
                dIf.aluSrc   = 1'b1;
                dIf.aSrcPc   = 1'b1;
                dIf.immExt   = immU;
            end
            OPC_JAL: begin
                dIf.regWrite = 1'b1;
                dIf.jump     = 1'b1;
                dIf.immExt   = immJ;
            end
            OPC_JALR: begin
                dIf.regWrite = 1'b1;
                dIf.jump     = 1'b1;
                dIf.jalr     = 1'b1;
            end
            OPC_BRANCH: begin
                dIf.branch   = 1'b1;
                dIf.immExt   = immB;
            end
            default: supported = 1'b0;
        endcase
    end

    // Unknown opcodes turn into a bubble
    assign dIf.valid   = validD && supported;
    assign dIf.funct3  = funct3;
    assign dIf.rs1Val  = rs1Val;
    assign dIf.rs2Val  = rs2Val;
    assign dIf.pc      = pcD;
    assign dIf.pcPlus4 = pcPlus4D;
    assign dIf.rd      = instrD[11:7];
    assign dIf.rs1     = rs1Addr;
    assign dIf.rs2     = rs2Addr;

endmodule

// File: decode/regFile.sv
`timescale 1ns/1ps

module regFile import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rs1Addr,
    input  regAddrT rs2Addr,
    output wordT    rs1Val,
    output wordT    rs2Val,
    input  logic    wen,
    input  regAddrT wAddr,
    input  wordT    wData
);

    // No storage for x0
    wordT regs [31:1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // Write-through covers a producer two ahead of the reader
    assign rs1Val = (rs1Addr == '0) ? '0 :
                    (wen && wAddr == rs1Addr) ? wData : regs[rs1Addr];
    assign rs2Val = (rs2Addr == '0) ? '0 :
                    (wen && wAddr == rs2Addr) ? wData : regs[rs2Addr];

endmodule

// File: execute/idExReg.sv
`timescale 1ns/1ps

module idExReg import pipePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stall,
    input  logic  flushE,
    deStageIf.dst dIf,
    deStageIf.src eIf
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            eIf.valid    <= 1'b0;
            eIf.regWrite <= 1'b0;
            eIf.aluCtrl  <= ALU_ADD;
            eIf.aluSrc   <= 1'b0;
            eIf.aSrcPc   <= 1'b0;
            eIf.jump     <= 1'b0;
            eIf.jalr     <= 1'b0;
            eIf.branch   <= 1'b0;
            eIf.funct3   <= '0;
            eIf.rs1Val   <= '0;
            eIf.rs2Val   <= '0;
            eIf.pc       <= '0;
            eIf.pcPlus4  <= '0;
            eIf.immExt   <= '0;
            eIf.rd       <= '0;
            eIf.rs1      <= '0;
            eIf.rs2      <= '0;
        end else if (flushE) begin
            // Bubble in place of the wrong-path instruction
            eIf.valid    <= 1'b0;
            eIf.regWrite <= 1'b0;
            eIf.aluCtrl  <= ALU_ADD;
            eIf.aluSrc   <= 1'b0;
            eIf.aSrcPc   <= 1'b0;
            eIf.jump     <= 1'b0;
            eIf.jalr     <= 1'b0;
            eIf.branch   <= 1'b0;
            eIf.funct3   <= '0;
            eIf.rs1Val   <= '0;
            eIf.rs2Val   <= '0;
            eIf.pc       <= '0;
            eIf.pcPlus4  <= '0;
            eIf.immExt   <= '0;
            eIf.rd       <= '0;
            eIf.rs1      <= '0;
            eIf.rs2      <= '0;
        end else if (!stall) begin
            eIf.valid    <= dIf.valid;
            eIf.regWrite <= dIf.regWrite;
            eIf.aluCtrl  <= dIf.aluCtrl;
            eIf.aluSrc   <= dIf.aluSrc;
            eIf.aSrcPc   <= dIf.aSrcPc;
            eIf.jump     <= dIf.jump;
            eIf.jalr     <= dIf.jalr;
            eIf.branch   <= dIf.branch;
            eIf.funct3   <= dIf.funct3;
            eIf.rs1Val   <= dIf.rs1Val;
            eIf.rs2Val   <= dIf.rs2Val;
            eIf.pc       <= dIf.pc;
            eIf.pcPlus4  <= dIf.pcPlus4;
            eIf.immExt   <= dIf.immExt;
            eIf.rd       <= dIf.rd;
            eIf.rs1      <= dIf.rs1;
            eIf.rs2      <= dIf.rs2;
        end
    end

endmodule

// File: execute/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    deStageIf.dst   eIf,
    input  fwdSelT  fwdA,
    input  fwdSelT  fwdB,
    output logic    redirect,
    output wordT    redirectPc,
    output logic    wbValid,
    output logic    wbWen,
    output regAddrT wbRd,
    output wordT    wbPc,
    output wordT    wbData
);

    wordT       srcA;
    wordT       srcB;
    wordT       aluA;
    wordT       aluB;
    wordT       aluResult;
    wordT       targetSum;
    logic [4:0] shamt;
    logic       taken;

    assign srcA  = (fwdA == FROMWB) ? wbData : eIf.rs1Val;
    assign srcB  = (fwdB == FROMWB) ? wbData : eIf.rs2Val;
    assign aluA  = eIf.aSrcPc ? eIf.pc : srcA;
    assign aluB  = eIf.aluSrc ? eIf.immExt : srcB;
    assign shamt = aluB[4:0];

    always_comb begin
        case (eIf.aluCtrl)
            ALU_ADD:   aluResult = aluA + aluB;
            ALU_SUB:   aluResult = aluA - aluB;
            ALU_SLL:   aluResult = aluA << shamt;
            ALU_SLT:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            ALU_SLTU:  aluResult = {31'b0, aluA < aluB};
            ALU_XOR:   aluResult = aluA ^ aluB;
            ALU_SRL:   aluResult = aluA >> shamt;
            ALU_SRA:   aluResult = wordT'($signed(aluA) >>> shamt);
            ALU_OR:    aluResult = aluA | aluB;
            ALU_AND:   aluResult = aluA & aluB;
            default:   aluResult = aluB;
        endcase
    end

    // Compare on the forwarded register values
    always_comb begin
        case (eIf.funct3)
            F3_BEQ:  taken = srcA == srcB;
            F3_BNE:  taken = srcA != srcB;
            F3_BLT:  taken = $signed(srcA) < $signed(srcB);
            F3_BGE:  taken = $signed(srcA) >= $signed(srcB);
            F3_BLTU: taken = srcA < srcB;
            F3_BGEU: taken = srcA >= srcB;
            default: taken = 1'b0;
        endcase
    end

    assign targetSum  = (eIf.jalr ? srcA : eIf.pc) + eIf.immExt;
    assign redirectPc = eIf.jalr ? {targetSum[31:1], 1'b0} : targetSum;
    assign redirect   = eIf.valid && (eIf.jump || (eIf.branch && taken));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            wbWen   <= 1'b0;
        end else if (!stall) begin
            wbValid <= eIf.valid;
            wbWen   <= eIf.valid && eIf.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wbRd   <= eIf.rd;
            wbPc   <= eIf.pc;
            // Jumps link to the next sequential pc
            wbData <= eIf.jump ? eIf.pcPlus4 : aluResult;
        end
    end

endmodule

// File: design/hazardCtrl.sv
`timescale 1ns/1ps

module hazardCtrl import isaPkg::*, pipePkg::*; (
    input  regAddrT rs1E,
    input  regAddrT rs2E,
    input  logic    wbValid,
    input  logic    wbWen,
    input  regAddrT wbRd,
    input  logic    redirect,
    input  logic    retireReady,
    output logic    stall,
    output logic    flushD,
    output logic    flushE,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB
);

    logic wbWrites;

    // The writeback register doubles as the retire slot
    assign stall = wbValid && !retireReady;

    // A redirect waits until the pipeline moves again
    assign flushD = redirect && !stall;
    assign flushE = redirect && !stall;

    // x0 is never forwarded
    assign wbWrites = wbValid && wbWen && wbRd != '0;

    assign fwdA = (wbWrites && wbRd == rs1E) ? FROMWB : REGVAL;
    assign fwdB = (wbWrites && wbRd == rs2E) ? FROMWB : REGVAL;

endmodule

// File: design/coreTop.sv
`timescale 1ns/1ps

module coreTop import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    output wordT    imemAddr,
    input  instrT   imemData,
    output logic    retireValid,
    input  logic    retireReady,
    output wordT    retirePc,
    output regAddrT retireRd,
    output logic    retireWen,
    output wordT    retireData
);

    logic    stall;
    logic    flushD;
    logic    flushE;
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    logic    redirect;
    wordT    redirectPc;
    instrT   instrD;
    wordT    pcD;
    wordT    pcPlus4D;
    logic    validD;
    regAddrT rs1Addr;
    regAddrT rs2Addr;
    wordT    rs1Val;
    wordT    rs2Val;
    logic    wbValid;
    logic    wbWen;
    regAddrT wbRd;
    wordT    wbPc;
    wordT    wbData;

    deStageIf dIf ();
    deStageIf eIf ();

    fetchUnit fetch (
        .clk, .rstN, .stall, .flushD, .redirect, .redirectPc,
        .imemAddr, .imemData, .instrD, .pcD, .pcPlus4D, .validD
    );

    instrDecoder decoder (
        .instrD, .pcD, .pcPlus4D, .validD, .rs1Val, .rs2Val,
        .rs1Addr, .rs2Addr, .dIf(dIf.src)
    );

    regFile regs (
        .clk, .rstN, .rs1Addr, .rs2Addr, .rs1Val, .rs2Val,
        .wen(wbWen), .wAddr(wbRd), .wData(wbData)
    );

    idExReg deReg (
        .clk, .rstN, .stall, .flushE, .dIf(dIf.dst), .eIf(eIf.src)
    );

    executeUnit execute (
        .clk, .rstN, .stall, .eIf(eIf.dst), .fwdA, .fwdB, .redirect, .redirectPc,
        .wbValid, .wbWen, .wbRd, .wbPc, .wbData
    );

    hazardCtrl hazard (
        .rs1E(eIf.rs1), .rs2E(eIf.rs2), .wbValid, .wbWen, .wbRd, .redirect,
        .retireReady, .stall, .flushD, .flushE, .fwdA, .fwdB
    );

    // Every instruction leaves from the writeback register
    assign retireValid = wbValid;
    assign retirePc    = wbPc;
    assign retireRd    = wbRd;
    assign retireWen   = wbWen;
    assign retireData  = wbData;

endmodule

// File: dv/coreTb.sv
`timescale 1ns/1ps

module coreTb import isaPkg::*, pipePkg::*; ();

    localparam int    PROG_WORDS     = 64;
    localparam int    TIMEOUT_CYCLES = 200;
    localparam instrT NOP_WORD       = 32'h0000_0013;

    typedef enum {K_OP, K_OPIMM, K_LUI, K_AUIPC, K_JAL, K_JALR, K_BRANCH} kindT;

    logic    clk;
    logic    rstN;
    wordT    imemAddr;
    instrT   imemData;
    logic    retireValid;
    logic    retireReady;
    wordT    retirePc;
    regAddrT retireRd;
    logic    retireWen;
    wordT    retireData;

    instrT   prog [PROG_WORDS];
    kindT    progKind [PROG_WORDS];
    regAddrT progRd [PROG_WORDS];
    regAddrT progRs1 [PROG_WORDS];
    regAddrT progRs2 [PROG_WORDS];
    funct3T  progF3 [PROG_WORDS];
    logic    progAlt [PROG_WORDS];
    wordT    progImm [PROG_WORDS];

    wordT    expPc [$];
    regAddrT expRd [$];
    logic    expWen [$];
    wordT    expData [$];

    logic [31:0] rngState = 32'd94962;
    logic        holdPending = 1'b0;
    wordT        heldPc;
    regAddrT     heldRd;
    logic        heldWen;
    wordT        heldData;

    coreTop i_dut (
        .clk, .rstN, .imemAddr, .imemData, .retireValid, .retireReady,
        .retirePc, .retireRd, .retireWen, .retireData
    );

    // Combinational instruction memory that reads NOPs past the program
    assign imemData = (imemAddr < PROG_WORDS * 4) ? prog[imemAddr[7:2]] : NOP_WORD;

    always #50 clk = ~clk;

    function automatic logic [15:0] nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState[31:16];
    endfunction

    function automatic int randBelow(int n);
        return int'(nextRand()) % n;
    endfunction

    function automatic wordT randWord();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = nextRand();
        lo = nextRand();
        return {hi, lo};
    endfunction

    task automatic reportMismatch(string testName, logic [31:0] expected, logic [31:0] actual);
        $display("ERR %s expected %h actual %h", testName, expected, actual);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    // Stores the fields for the model and encodes the word
    task automatic setSlot(int i, kindT k, regAddrT rd, regAddrT rs1, regAddrT rs2,
                           funct3T f3, logic alt, wordT imm);
        progKind[i] = k;
        progRd[i]   = rd;
        progRs1[i]  = rs1;
        progRs2[i]  = rs2;
        progF3[i]   = f3;
        progAlt[i]  = alt;
        progImm[i]  = imm;
        case (k)
            K_OP:     prog[i] = {alt ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, OPC_OP};
            K_OPIMM:  prog[i] = {imm[11:0], rs1, f3, rd, OPC_OPIMM};
            K_LUI:    prog[i] = {imm[31:12], rd, OPC_LUI};
            K_AUIPC:  prog[i] = {imm[31:12], rd, OPC_AUIPC};
            K_JAL:    prog[i] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
            K_JALR:   prog[i] = {imm[11:0], rs1, 3'b000, rd, OPC_JALR};
            default:  prog[i] = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
        endcase
    endtask

    task automatic genProgram();
        int      i;
        int      r;
        int      t;
        int      lim;
        int      off;
        int      step;
        regAddrT base;
        funct3T  f3;
        logic    alt;
        wordT    w;
        funct3T  brKinds [6];
        logic    isTarget [PROG_WORDS];
        brKinds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (i = 0; i < PROG_WORDS; i++) begin
            isTarget[i] = 1'b0;
        end
        i = 0;
        while (i < PROG_WORDS) begin
            r = randBelow(100);
            lim = (i + 8 < PROG_WORDS) ? 8 : PROG_WORDS - 1 - i;
            // A JALR entered by a jump would see a stale base register
            if (r < 8 && i < PROG_WORDS - 2 && !isTarget[i + 1]) begin
                // Forward target loaded just before the JALR with an odd sum half the time
                t    = i + 2 + randBelow((i + 9 < PROG_WORDS) ? 8 : PROG_WORDS - 2 - i);
                off  = randBelow(32) - 16;
                base = regAddrT'(1 + randBelow(7));
                isTarget[t] = 1'b1;
                setSlot(i, K_OPIMM, base, 5'd0, 5'd0, F3_ADD, 1'b0,
                        wordT'(4 * t - off + randBelow(2)));
                setSlot(i + 1, K_JALR, regAddrT'(randBelow(8)), base, 5'd0, 3'b000, 1'b0,
                        wordT'(off));
                i += 2;
            end else if (r < 20 && i < PROG_WORDS - 1) begin
                step = 1 + randBelow(lim);
                isTarget[i + step] = 1'b1;
                setSlot(i, K_BRANCH, 5'd0, regAddrT'(randBelow(8)), regAddrT'(randBelow(8)),
                        brKinds[randBelow(6)], 1'b0, wordT'(4 * step));
                i++;
            end else if (r < 28 && i < PROG_WORDS - 1) begin
                step = 1 + randBelow(lim);
                isTarget[i + step] = 1'b1;
                setSlot(i, K_JAL, regAddrT'(randBelow(8)), 5'd0, 5'd0, 3'b000, 1'b0,
                        wordT'(4 * step));
                i++;
            end else if (r < 40) begin
                w = randWord() & 32'hFFFF_F000;
                setSlot(i, (r < 34) ? K_LUI : K_AUIPC, regAddrT'(randBelow(8)), 5'd0, 5'd0,
                        3'b000, 1'b0, w);
                i++;
            end else if (r < 70) begin
                f3  = funct3T'(randBelow(8));
                alt = (f3 == F3_SR) ? logic'(randBelow(2)) : 1'b0;
                w   = randWord();
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    w = {20'b0, alt ? 7'b0100000 : 7'b0, w[4:0]};
                end else begin
                    w = {{20{w[11]}}, w[11:0]};
                end
                setSlot(i, K_OPIMM, regAddrT'(randBelow(8)), regAddrT'(randBelow(8)), 5'd0,
                        f3, alt, w);
                i++;
            end else begin
                f3  = funct3T'(randBelow(8));
                alt = (f3 == F3_ADD || f3 == F3_SR) ? logic'(randBelow(2)) : 1'b0;
                setSlot(i, K_OP, regAddrT'(randBelow(8)), regAddrT'(randBelow(8)),
                        regAddrT'(randBelow(8)), f3, alt, '0);
                i++;
            end
        end
    endtask

    function automatic wordT aluModel(funct3T f3, logic alt, wordT a, wordT b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(funct3T f3, wordT a, wordT b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Architectural run from pc 0 until the pc leaves the program
    task automatic runModel();
        wordT regs [32];
        wordT pc;
        wordT nextPc;
        wordT a;
        wordT b;
        wordT res;
        int   idx;
        logic wen;
        for (idx = 0; idx < 32; idx++) begin
            regs[idx] = '0;
        end
        pc = RESET_PC;
        while (pc < PROG_WORDS * 4) begin
            idx    = pc[7:2];
            a      = regs[progRs1[idx]];
            b      = regs[progRs2[idx]];
            nextPc = pc + 4;
            wen    = 1'b1;
            res    = '0;
            case (progKind[idx])
                K_OP:    res = aluModel(progF3[idx], progAlt[idx], a, b);
                K_OPIMM: res = aluModel(progF3[idx], progAlt[idx], a, progImm[idx]);
                K_LUI:   res = progImm[idx];
                K_AUIPC: res = pc + progImm[idx];
                K_JAL: begin
                    res    = pc + 4;
                    nextPc = pc + progImm[idx];
                end
                K_JALR: begin
                    res    = pc + 4;
                    nextPc = (a + progImm[idx]) & ~32'd1;
                end
                default: begin
                    wen = 1'b0;
                    if (branchModel(progF3[idx], a, b)) begin
                        nextPc = pc + progImm[idx];
                    end
                end
            endcase
            expPc.push_back(pc);
            expRd.push_back(progRd[idx]);
            expWen.push_back(wen);
            expData.push_back(res);
            if (wen && progRd[idx] != 5'd0) begin
                regs[progRd[idx]] = res;
            end
            pc = nextPc;
        end
    endtask

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1) begin
            if (cycles == TIMEOUT_CYCLES) begin
                abortRun("reset was not released within the timeout");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // Returns at the falling edge before the transfer edge
    task automatic waitRetire(int k);
        int cycles;
        cycles = 0;
        while (!(retireValid === 1'b1 && retireReady === 1'b1)) begin
            if (cycles == TIMEOUT_CYCLES) begin
                abortRun($sformatf("retirement %0d did not arrive within %0d cycles",
                                   k, TIMEOUT_CYCLES));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic checkRetire(int k);
        assert (retirePc === expPc[k])
            else reportMismatch($sformatf("retire %0d pc", k), expPc[k], retirePc);
        assert (retireWen === expWen[k])
            else reportMismatch($sformatf("retire %0d wen", k), expWen[k], retireWen);
        // rd and data carry nothing for a branch
        if (expWen[k]) begin
            assert (retireRd === expRd[k])
                else reportMismatch($sformatf("retire %0d rd", k), expRd[k], retireRd);
            assert (retireData === expData[k])
                else reportMismatch($sformatf("retire %0d data", k), expData[k], retireData);
        end
    endtask

    always @(posedge clk) begin
        retireReady <= (randBelow(4) != 0);
    end

    // Outputs must hold while a retirement waits on retireReady
    always @(negedge clk) begin
        if (rstN && holdPending) begin
            assert (retireValid === 1'b1)
                else abortRun("retireValid dropped while retireReady was low");
            assert (retirePc === heldPc)
                else reportMismatch("hold retirePc", heldPc, retirePc);
            assert (retireRd === heldRd)
                else reportMismatch("hold retireRd", heldRd, retireRd);
            assert (retireWen === heldWen)
                else reportMismatch("hold retireWen", heldWen, retireWen);
            assert (retireData === heldData)
                else reportMismatch("hold retireData", heldData, retireData);
        end
        holdPending = rstN && retireValid && !retireReady;
        heldPc      = retirePc;
        heldRd      = retireRd;
        heldWen     = retireWen;
        heldData    = retireData;
    end

    initial begin
        int k;
        clk         = 1'b0;
        rstN        = 1'b0;
        retireReady = 1'b0;
        genProgram();
        runModel();
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        waitResetRelease();
        assert (retireValid === 1'b0)
            else reportMismatch("reset retireValid", 32'd0, retireValid);
        assert (imemAddr === RESET_PC)
            else reportMismatch("reset imemAddr", RESET_PC, imemAddr);
        for (k = 0; k < expPc.size(); k++) begin
            waitRetire(k);
            checkRetire(k);
            @(negedge clk);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: list.f
common/isaPkg.sv
common/pipePkg.sv
common/deStageIf.sv
design/fetchUnit.sv
decode/instrDecoder.sv
decode/regFile.sv
execute/idExReg.sv
execute/executeUnit.sv
design/hazardCtrl.sv
design/coreTop.sv
dv/coreTb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - common/isaPkg.sv
  - common/pipePkg.sv
  - common/deStageIf.sv
  - design/fetchUnit.sv
  - decode/instrDecoder.sv
  - decode/regFile.sv
  - execute/idExReg.sv
  - execute/executeUnit.sv
  - design/hazardCtrl.sv
  - design/coreTop.sv
  - target: simulation
    files:
      - dv/coreTb.sv
